// ==== common/rv_pred_pkg.sv ====
`default_nettype none

package rv_pred_pkg;

  // Width of every address in the predictor (PC, return address, target)
  localparam int XLEN = 32;

  // Number of return addresses held by the stack
  localparam int RAS_DEPTH = 8;

  // The pointer indexes one of RAS_DEPTH entries
  localparam int RAS_SP_BITS = $clog2(RAS_DEPTH);

  // The count must also represent the full state, so it needs one value more
  localparam int RAS_COUNT_BITS = $clog2(RAS_DEPTH + 1);

  typedef logic [XLEN-1:0] xaddr_t;

  // Major opcodes of the two unconditional jumps
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  // JALR is only defined with funct3 zero
  localparam logic [2:0] F3_JALR = 3'b000;

  // Standard link registers, ra and the alternate link t0
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_T0 = 5'd5;

  // J-type layout, with the immediate scattered across the upper bits
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fields_t;

  // I-type layout, which JALR uses for its base register and offset
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // One instruction word seen through both encodings
  // The opcode and rd occupy the same bits in either view
  typedef union packed {
    j_fields_t j;
    i_fields_t i;
  } rv_insn_u;

  // True for x1 and x5, the registers the hint rules treat as links
  function automatic logic is_link_reg(input logic [4:0] r);
    return (r == REG_RA) || (r == REG_T0);
  endfunction

endpackage

`default_nettype wire

// ==== ras/rv_ras.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_ras (
  input  logic                 clk,
  input  logic                 rst_n,

  // Update side, driven from the MEM stage
  input  logic                 push_en,
  input  rv_pred_pkg::xaddr_t  push_addr,
  input  logic                 pop_en,

  // Lookup side, read by the fetch predecoder
  output logic                 ras_valid,
  output rv_pred_pkg::xaddr_t  ras_target
);

  import rv_pred_pkg::*;

  // Entry storage carries no reset, the count says what is meaningful
  xaddr_t                    stack_mem [RAS_DEPTH];

  // Pointer to the current top entry
  logic [RAS_SP_BITS-1:0]    sp;

  // Number of live entries, saturating at RAS_DEPTH
  logic [RAS_COUNT_BITS-1:0] count;

  logic [RAS_SP_BITS-1:0]    sp_next;
  logic [RAS_COUNT_BITS-1:0] count_next;

  logic                      stack_empty;
  logic                      stack_full;

  assign stack_empty = (count == '0);
  assign stack_full  = (count == RAS_COUNT_BITS'(RAS_DEPTH));

  // Next pointer and count
  always_comb begin
    sp_next    = sp;
    count_next = count;

    if (push_en && pop_en) begin
      // Replace the top in place
      // Pointer and count stay where they are
      sp_next    = sp;
      count_next = count;
    end else if (push_en) begin
      // Advance with wrap at the end of the buffer
      if (sp == RAS_SP_BITS'(RAS_DEPTH - 1)) begin
        sp_next = '0;
      end else begin
        sp_next = sp + 1'b1;
      end

      // When full the oldest entry is overwritten, so the count holds
      if (!stack_full) begin
        count_next = count + 1'b1;
      end
    end else if (pop_en) begin
      // Popping an empty stack is ignored
      if (!stack_empty) begin
        if (sp == '0) begin
          sp_next = RAS_SP_BITS'(RAS_DEPTH - 1);
        end else begin
          sp_next = sp - 1'b1;
        end
        count_next = count - 1'b1;
      end
    end
  end

  // Lookup
  // A push in MEM this cycle is forwarded so a return fetched in the same
  // cycle already sees the new top
  always_comb begin
    if (push_en) begin
      ras_valid  = 1'b1;
      ras_target = push_addr;
    end else if (!stack_empty) begin
      ras_valid  = 1'b1;
      ras_target = stack_mem[sp];
    end else begin
      ras_valid  = 1'b0;
      ras_target = '0;
    end
  end

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sp    <= '0;
      count <= '0;
    end else begin
      sp    <= sp_next;
      count <= count_next;
    end
  end

  // Entry write
  // The new top lands at the next pointer, which for a replace is the
  // current top
  always_ff @(posedge clk) begin
    if (rst_n && push_en) begin
      stack_mem[sp_next] <= push_addr;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_link_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_link_decode (
  // Resolved instruction in the MEM stage
  input  logic                  mem_valid,
  input  rv_pred_pkg::xaddr_t   mem_pc,
  input  rv_pred_pkg::rv_insn_u mem_insn,

  // Stack update requests
  output logic                  push_en,
  output logic                  pop_en,
  output rv_pred_pkg::xaddr_t   push_addr
);

  import rv_pred_pkg::*;

  logic       is_jal;
  logic       is_jalr;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rd_link;
  logic       rs1_link;
  logic       is_call;
  logic       is_ret;
  logic       same_link;

  // Opcode and rd sit at the same bits in both views
  // The i view also exposes rs1 for JALR
  assign rd  = mem_insn.i.rd;
  assign rs1 = mem_insn.i.rs1;

  assign is_jal  = (mem_insn.i.opcode == OPC_JAL);
  assign is_jalr = (mem_insn.i.opcode == OPC_JALR) && (mem_insn.i.funct3 == F3_JALR);

  assign rd_link  = is_link_reg(rd);
  assign rs1_link = is_link_reg(rs1);

  // Any jump writing a link register is a call
  assign is_call = (is_jal || is_jalr) && rd_link;

  // Only JALR reads rs1
  // For JAL those bits belong to the immediate
  assign is_ret = is_jalr && rs1_link;

  // Both roles with the same register means a plain call
  assign same_link = (rd == rs1);

  // Apply the hint table
  // Call only pushes, return only pops, and a coroutine swap with different
  // link registers does both to replace the top
  always_comb begin
    push_en = 1'b0;
    pop_en  = 1'b0;

    if (mem_valid) begin
      if (is_call && is_ret) begin
        push_en = 1'b1;
        pop_en  = !same_link;
      end else if (is_call) begin
        push_en = 1'b1;
      end else if (is_ret) begin
        pop_en = 1'b1;
      end
    end
  end

  // Link value the jump writes, which is where the callee returns to
  assign push_addr = mem_pc + XLEN'(4);

endmodule

`default_nettype wire

// ==== verilog/rv_fetch_predict.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_predict (
  // Fetched word and its address
  input  logic                  if_valid,
  input  rv_pred_pkg::xaddr_t   if_pc,
  input  rv_pred_pkg::rv_insn_u if_insn,

  // Top of the return address stack
  input  logic                  ras_valid,
  input  rv_pred_pkg::xaddr_t   ras_target,

  // Next fetch address
  output logic                  pred_taken,
  output rv_pred_pkg::xaddr_t   pred_pc
);

  import rv_pred_pkg::*;

  logic   is_jal;
  logic   is_ret;
  xaddr_t j_imm;
  xaddr_t jal_target;
  xaddr_t seq_pc;

  // Direct jump, whose target is known from the word alone
  assign is_jal = (if_insn.j.opcode == OPC_JAL);

  // Return pattern
  // JALR that discards the link and jumps through x1 or x5
  assign is_ret = (if_insn.i.opcode == OPC_JALR) &&
                  (if_insn.i.funct3 == F3_JALR) &&
                  (if_insn.i.rd == REG_ZERO) &&
                  is_link_reg(if_insn.i.rs1);

  // Rebuild the J immediate from its scattered fields
  // Bit 0 is always zero and bit 20 is the sign
  assign j_imm = {
    {(XLEN - 20){if_insn.j.imm_20}},
    if_insn.j.imm_19_12,
    if_insn.j.imm_11,
    if_insn.j.imm_10_1,
    1'b0
  };

  assign jal_target = if_pc + j_imm;
  assign seq_pc     = if_pc + XLEN'(4);

  // Choose the next PC
  // JAL always redirects, a return only when the stack has something
  always_comb begin
    pred_taken = 1'b0;
    pred_pc    = seq_pc;

    if (if_valid) begin
      if (is_jal) begin
        pred_taken = 1'b1;
        pred_pc    = jal_target;
      end else if (is_ret && ras_valid) begin
        pred_taken = 1'b1;
        pred_pc    = ras_target;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rv_ret_predict_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_ret_predict_top (
  input  logic                  clk,
  input  logic                  rst_n,

  // MEM stage, resolved jumps that correct the stack
  input  logic                  mem_valid,
  input  rv_pred_pkg::xaddr_t   mem_pc,
  input  rv_pred_pkg::rv_insn_u mem_insn,

  // IF stage, the word being fetched this cycle
  input  logic                  if_valid,
  input  rv_pred_pkg::xaddr_t   if_pc,
  input  rv_pred_pkg::rv_insn_u if_insn,

  // Prediction back to the fetch unit
  output logic                  pred_taken,
  output rv_pred_pkg::xaddr_t   pred_pc
);

  import rv_pred_pkg::*;

  // MEM decoder to stack
  logic   push_en;
  logic   pop_en;
  xaddr_t push_addr;

  // Stack to fetch predecoder
  logic   ras_valid;
  xaddr_t ras_target;

  rv_link_decode link_decode_i (
    .mem_valid (mem_valid),
    .mem_pc    (mem_pc),
    .mem_insn  (mem_insn),
    .push_en   (push_en),
    .pop_en    (pop_en),
    .push_addr (push_addr)
  );

  rv_ras ras_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_en    (push_en),
    .push_addr  (push_addr),
    .pop_en     (pop_en),
    .ras_valid  (ras_valid),
    .ras_target (ras_target)
  );

  // Purely combinational, so the prediction follows the IF inputs in the
  // same cycle
  rv_fetch_predict fetch_predict_i (
    .if_valid   (if_valid),
    .if_pc      (if_pc),
    .if_insn    (if_insn),
    .ras_valid  (ras_valid),
    .ras_target (ras_target),
    .pred_taken (pred_taken),
    .pred_pc    (pred_pc)
  );

endmodule

`default_nettype wire

// ==== tb/rv_ret_predict_tb_table.svh ====
// Columns: mem_valid, mem_pc, mem_insn, if_valid, if_pc, if_insn, pred_taken, pred_pc
// Each row is one cycle, and the expected prediction sees pushes of the same row

// Empty stack after reset, so returns fall through while JAL still redirects
add_row(0, 'h0, NOP, 1, 'h100, RET_RA, 0, 'h104);
add_row(0, 'h0, NOP, 1, 'h104, RET_T0, 0, 'h108);
add_row(0, 'h0, NOP, 1, 'h200, jal_word(1, 'h40), 1, 'h240);
add_row(0, 'h0, NOP, 1, 'h200, jal_word(1, 'h12b44), 1, 'h12d44);
add_row(0, 'h0, NOP, 1, 'h300, jal_word(0, -'h20), 1, 'h2e0);

// Three nested calls through JAL x1, JALR x1 and JAL x5
add_row(1, 'h1000, jal_word(1, 'h100), 1, 'h400, NOP, 0, 'h404);
add_row(1, 'h2000, jalr_word(1, 6), 1, 'h404, NOP, 0, 'h408);
add_row(1, 'h3000, jal_word(5, 'h8), 1, 'h408, NOP, 0, 'h40c);
add_row(0, 'h0, NOP, 1, 'h500, RET_RA, 1, 'h3004);
// A pop only shows up after the edge
add_row(1, 'h3100, RET_RA, 1, 'h504, RET_RA, 1, 'h3004);
add_row(0, 'h0, NOP, 1, 'h508, RET_RA, 1, 'h2004);
add_row(1, 'h2100, RET_T0, 1, 'h50c, NOP, 0, 'h510);
add_row(0, 'h0, NOP, 1, 'h510, RET_T0, 1, 'h1004);
add_row(1, 'h1100, RET_RA, 1, 'h514, RET_RA, 1, 'h1004);
add_row(0, 'h0, NOP, 1, 'h518, RET_RA, 0, 'h51c);

// Call in MEM and return in IF together on an empty stack
add_row(1, 'h4000, jal_word(1, 'h10), 1, 'h600, RET_RA, 1, 'h4004);
add_row(1, 'h4100, RET_RA, 1, 'h604, NOP, 0, 'h608);
add_row(0, 'h0, NOP, 1, 'h610, RET_RA, 0, 'h614);

// Ten calls into an eight entry stack, the two oldest are lost
add_row(1, 'h5000, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5010, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5020, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5030, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5040, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5050, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5060, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5070, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5080, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5090, jal_word(1, 'h80), 0, 'h700, NOP, 0, 'h704);
add_row(1, 'h5800, RET_RA, 1, 'h800, RET_RA, 1, 'h5094);
add_row(1, 'h5800, RET_RA, 1, 'h804, RET_RA, 1, 'h5084);
add_row(1, 'h5800, RET_RA, 1, 'h808, RET_RA, 1, 'h5074);
add_row(1, 'h5800, RET_RA, 1, 'h80c, RET_RA, 1, 'h5064);
add_row(1, 'h5800, RET_RA, 1, 'h810, RET_RA, 1, 'h5054);
add_row(1, 'h5800, RET_RA, 1, 'h814, RET_RA, 1, 'h5044);
add_row(1, 'h5800, RET_RA, 1, 'h818, RET_RA, 1, 'h5034);
add_row(1, 'h5800, RET_RA, 1, 'h81c, RET_RA, 1, 'h5024);
add_row(0, 'h0, NOP, 1, 'h820, RET_RA, 0, 'h824);
// Extra pop on the empty stack, then one push and pop shows the count held at zero
add_row(1, 'h5800, RET_RA, 1, 'h824, RET_RA, 0, 'h828);
add_row(0, 'h0, NOP, 1, 'h828, RET_RA, 0, 'h82c);
add_row(1, 'h6000, jal_word(1, 'h20), 1, 'h82c, NOP, 0, 'h830);
add_row(1, 'h6100, RET_RA, 1, 'h830, RET_RA, 1, 'h6004);
add_row(0, 'h0, NOP, 1, 'h834, RET_RA, 0, 'h838);

// Coroutine swap through JALR x1, 0(x5) replaces the top and is forwarded
add_row(1, 'h7000, jal_word(1, 'h40), 1, 'h900, NOP, 0, 'h904);
add_row(1, 'h7100, jal_word(1, 'h40), 1, 'h904, NOP, 0, 'h908);
add_row(1, 'h7200, jalr_word(1, 5), 1, 'h908, RET_RA, 1, 'h7204);
add_row(0, 'h0, NOP, 1, 'h90c, RET_RA, 1, 'h7204);
add_row(1, 'h7300, RET_RA, 1, 'h910, RET_RA, 1, 'h7204);
add_row(0, 'h0, NOP, 1, 'h914, RET_RA, 1, 'h7004);
// JALR x1, 0(x1) is a plain push
add_row(1, 'h7400, jalr_word(1, 1), 1, 'h918, NOP, 0, 'h91c);
add_row(1, 'h7500, RET_RA, 1, 'h91c, RET_RA, 1, 'h7404);
add_row(1, 'h7600, RET_RA, 1, 'h920, RET_RA, 1, 'h7004);
add_row(0, 'h0, NOP, 1, 'h924, RET_RA, 0, 'h928);

// Words that are neither call nor return, and invalid MEM rows, leave the stack alone
add_row(1, 'h8000, jal_word(1, 'h40), 1, 'ha00, NOP, 0, 'ha04);
add_row(1, 'h8100, NOP, 1, 'ha04, RET_RA, 1, 'h8004);
add_row(1, 'h8200, jal_word(0, 'h40), 1, 'ha08, RET_RA, 1, 'h8004);
add_row(1, 'h8300, jalr_word(0, 6), 1, 'ha0c, RET_RA, 1, 'h8004);
add_row(0, 'h8400, jal_word(1, 'h40), 1, 'ha10, RET_RA, 1, 'h8004);
add_row(0, 'h8500, RET_RA, 1, 'ha14, RET_RA, 1, 'h8004);
add_row(0, 'h8600, RET_T0, 1, 'ha18, RET_T0, 1, 'h8004);
// An invalid fetch never redirects
add_row(0, 'h0, NOP, 0, 'ha1c, jal_word(1, 'h40), 0, 'ha20);
add_row(0, 'h0, NOP, 0, 'ha20, RET_RA, 0, 'ha24);
// Indirect jump and indirect call in IF are not returns
add_row(0, 'h0, NOP, 1, 'ha24, jalr_word(0, 6), 0, 'ha28);
add_row(0, 'h0, NOP, 1, 'ha28, jalr_word(1, 1), 0, 'ha2c);
add_row(1, 'h8700, RET_RA, 1, 'ha2c, RET_RA, 1, 'h8004);
add_row(0, 'h0, NOP, 1, 'ha30, RET_RA, 0, 'ha34);

// ==== tb/rv_ret_predict_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_ret_predict_tb;

  import rv_pred_pkg::*;

  localparam time CLK_PERIOD    = 100ns;
  localparam time DRIVE_DELAY   = 5ns;
  localparam time SAMPLE_LEAD   = 5ns;
  localparam int  RESET_CYCLES  = 2;
  localparam int  RESET_TIMEOUT = 20;
  localparam int  MAX_ROWS      = 80;

  // Instruction words used throughout the table
  localparam rv_insn_u NOP    = 32'h0000_0013;
  localparam rv_insn_u RET_RA = 32'h0000_8067;
  localparam rv_insn_u RET_T0 = 32'h0002_8067;

  logic     clk;
  logic     rst_n = 1'b0;
  logic     mem_valid;
  xaddr_t   mem_pc;
  rv_insn_u mem_insn;
  logic     if_valid;
  xaddr_t   if_pc;
  rv_insn_u if_insn;
  logic     pred_taken;
  xaddr_t   pred_pc;

  // The included table fills one entry per row
  logic     row_mem_valid [MAX_ROWS];
  xaddr_t   row_mem_pc [MAX_ROWS];
  rv_insn_u row_mem_insn [MAX_ROWS];
  logic     row_if_valid [MAX_ROWS];
  xaddr_t   row_if_pc [MAX_ROWS];
  rv_insn_u row_if_insn [MAX_ROWS];
  logic     row_exp_taken [MAX_ROWS];
  xaddr_t   row_exp_pc [MAX_ROWS];
  int       n_rows = 0;

  int taken_errors = 0;
  int pc_errors    = 0;
  int other_errors = 0;

  rv_ret_predict_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_valid  (mem_valid),
    .mem_pc     (mem_pc),
    .mem_insn   (mem_insn),
    .if_valid   (if_valid),
    .if_pc      (if_pc),
    .if_insn    (if_insn),
    .pred_taken (pred_taken),
    .pred_pc    (pred_pc)
  );

  // Builds a JAL word and scatters the offset into the J-type fields
  function automatic rv_insn_u jal_word(input logic [4:0] rd, input logic [20:0] imm);
    rv_insn_u w;
    w.j.imm_20    = imm[20];
    w.j.imm_10_1  = imm[10:1];
    w.j.imm_11    = imm[11];
    w.j.imm_19_12 = imm[19:12];
    w.j.rd        = rd;
    w.j.opcode    = OPC_JAL;
    return w;
  endfunction

  // Builds a JALR word with a zero offset
  function automatic rv_insn_u jalr_word(input logic [4:0] rd, input logic [4:0] rs1);
    rv_insn_u w;
    w.i.imm    = '0;
    w.i.rs1    = rs1;
    w.i.funct3 = 3'b000;
    w.i.rd     = rd;
    w.i.opcode = OPC_JALR;
    return w;
  endfunction

  task automatic add_row(input logic mv, input xaddr_t mpc, input rv_insn_u minsn,
                         input logic iv, input xaddr_t ipc, input rv_insn_u iinsn,
                         input logic exp_taken, input xaddr_t exp_pc);
    if (n_rows >= MAX_ROWS) begin
      other_errors++;
      $display("Stimulus table holds more rows than its storage of %0d", MAX_ROWS);
    end else begin
      row_mem_valid[n_rows] = mv;
      row_mem_pc[n_rows]    = mpc;
      row_mem_insn[n_rows]  = minsn;
      row_if_valid[n_rows]  = iv;
      row_if_pc[n_rows]     = ipc;
      row_if_insn[n_rows]   = iinsn;
      row_exp_taken[n_rows] = exp_taken;
      row_exp_pc[n_rows]    = exp_pc;
      n_rows++;
    end
  endtask

  task automatic load_table();
    `include "rv_ret_predict_tb_table.svh"
  endtask

  task automatic check_taken(input int row, input logic expected, input logic actual);
    if (actual !== expected) begin
      taken_errors++;
      $display("Fail %0d ns row %0d pred_taken expected %b got %b",
               $time, row, expected, actual);
    end
  endtask

  task automatic check_pc(input int row, input xaddr_t expected, input xaddr_t actual);
    if (actual !== expected) begin
      pc_errors++;
      $display("Fail %0d ns row %0d pred_pc expected %h got %h",
               $time, row, expected, actual);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Reset is released just after an edge so the first row starts clean
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
  end

  initial begin
    int waited;
    mem_valid = 1'b0;
    mem_pc    = '0;
    mem_insn  = NOP;
    if_valid  = 1'b0;
    if_pc     = '0;
    if_insn   = NOP;
    load_table();
    if (n_rows == 0) begin
      other_errors++;
      $display("Stimulus table is empty");
    end
    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      other_errors++;
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
    end else begin
      for (int r = 0; r < n_rows; r++) begin
        @(posedge clk);
        #DRIVE_DELAY;
        mem_valid = row_mem_valid[r];
        mem_pc    = row_mem_pc[r];
        mem_insn  = row_mem_insn[r];
        if_valid  = row_if_valid[r];
        if_pc     = row_if_pc[r];
        if_insn   = row_if_insn[r];
        // Outputs are combinational, so they have settled well before the next edge
        #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);
        check_taken(r, row_exp_taken[r], pred_taken);
        check_pc(r, row_exp_pc[r], pred_pc);
      end
    end
    $display("Rows %0d, errors: pred_taken %0d, pred_pc %0d, other %0d",
             n_rows, taken_errors, pc_errors, other_errors);
    if (taken_errors + pc_errors + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rv_ret_predict.f ====
+incdir+tb
common/rv_pred_pkg.sv
ras/rv_ras.sv
verilog/rv_link_decode.sv
verilog/rv_fetch_predict.sv
verilog/rv_ret_predict_top.sv
tb/rv_ret_predict_tb.sv
